//--- src/core_pkg.sv
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_sel_t;
    typedef logic [2:0]  op_class_t;

    // Instruction classes assigned by decode
    localparam op_class_t class_alu    = 3'd0;
    localparam op_class_t class_lui    = 3'd1;
    localparam op_class_t class_load   = 3'd2;
    localparam op_class_t class_store  = 3'd3;
    localparam op_class_t class_branch = 3'd4;
    localparam op_class_t class_jal    = 3'd5;

    localparam addr_t reset_pc = 32'h0000_0000;

    // RV32I major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    typedef struct packed {
        addr_t  addr;
        instr_t instr;
    } fetch_out_t;

    typedef struct packed {
        op_class_t  op_class;
        logic [3:0] alu_fn;     // {sub, funct3}
        reg_sel_t   rd;
        logic       rd_write;
        word_t      op_a;
        word_t      op_b;
        word_t      store_data;
        word_t      imm;
        addr_t      addr;
        logic       bne;
    } decode_out_t;

    typedef struct packed {
        reg_sel_t rd;
        logic     write;
        word_t    result;
        addr_t    addr;
        addr_t    next_pc;
    } exec_out_t;

    typedef struct packed {
        logic  req;
        addr_t addr;
    } imem_req_t;

    typedef struct packed {
        logic  req;
        logic  write;
        addr_t addr;
        word_t wdata;
    } dmem_req_t;

    typedef struct packed {
        logic  ack;
        word_t rdata;
    } mem_rsp_t;

endpackage

//--- src/int_regfile.sv
`timescale 1ns/1ps

module int_regfile import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     write_enable,
    input  reg_sel_t write_sel,
    input  word_t    write_data,
    input  reg_sel_t read1_sel,
    input  reg_sel_t read2_sel,
    input  reg_sel_t read3_sel,
    output word_t    read1_data,
    output word_t    read2_data,
    output word_t    read3_data
);

    word_t regs [32];   // Entry 0 is never written

    always_ff @(posedge clk) begin
        if (!rst && write_enable && write_sel != '0)
            regs[write_sel] <= write_data;
    end

    assign read1_data = read1_sel == '0 ? '0 : regs[read1_sel];
    assign read2_data = read2_sel == '0 ? '0 : regs[read2_sel];
    assign read3_data = read3_sel == '0 ? '0 : regs[read3_sel];

endmodule

//--- src/ifetch.sv
`timescale 1ns/1ps

module ifetch import core_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  addr_t      redirect_addr,
    output imem_req_t  imem_req,
    input  mem_rsp_t   imem_rsp,
    output fetch_out_t fetch_out,
    input  logic       next_stalled,
    output logic       stall_next
);

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_wait,
        fetch_discard
    } fetch_state_t;

    fetch_state_t state;
    addr_t pc;              // Address of the next fetch
    logic  out_valid;
    logic  take;
    logic  capture;

    assign take    = out_valid && !next_stalled;
    assign capture = state == fetch_wait && imem_rsp.ack && !flush;

    assign imem_req.req  = state == fetch_wait;
    assign imem_req.addr = pc;
    assign stall_next    = !out_valid;

    always_ff @(posedge clk) begin
        if (capture) begin
            fetch_out.addr  <= pc;
            fetch_out.instr <= imem_rsp.rdata;
        end

        if (rst) begin
            state     <= fetch_idle;
            pc        <= reset_pc;
            out_valid <= 1'b0;
        end else begin
            if (take)
                out_valid <= 1'b0;
            case (state)
                fetch_idle: begin
                    // Only request once the output slot frees up
                    if (!flush && (!out_valid || take))
                        state <= fetch_wait;
                end
                fetch_wait: begin
                    if (imem_rsp.ack)
                        state <= fetch_idle;
                    else if (flush)
                        state <= fetch_discard;  // Ack still owed for the old address
                    if (capture) begin
                        out_valid <= 1'b1;
                        pc        <= pc + 32'd4;
                    end
                end
                default: begin
                    if (imem_rsp.ack)
                        state <= fetch_idle;
                end
            endcase
            if (flush) begin
                pc        <= redirect_addr;
                out_valid <= 1'b0;
            end
        end
    end

endmodule

//--- src/decode.sv
`timescale 1ns/1ps

module decode import core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  fetch_out_t  fetch_in,
    input  logic        prev_stalled,
    output logic        stall_prev,
    input  logic        next_stalled,
    output logic        stall_next,
    output reg_sel_t    read1_sel,
    output reg_sel_t    read2_sel,
    input  word_t       read1_data,
    input  word_t       read2_data,
    input  exec_out_t   bypass_exec,
    input  logic        bypass_exec_valid,
    input  exec_out_t   bypass_wb,
    input  logic        bypass_wb_valid,
    input  reg_sel_t    load_pending_rd,
    input  logic        load_pending,
    output decode_out_t decode_out
);

    instr_t     instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_sel_t   rs1, rs2, rd;
    op_class_t  op_class;
    word_t      imm;
    logic       uses_rs1, uses_rs2, rd_write;
    word_t      rs1_val, rs2_val;
    logic       out_valid, hazard, accept;

    assign instr  = fetch_in.instr;
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign read1_sel = rs1;
    assign read2_sel = rs2;

    always_comb begin
        op_class = class_alu;
        imm      = {{20{instr[31]}}, instr[31:20]};     // I-type
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        rd_write = 1'b0;
        case (opcode)
            opc_op: begin
                uses_rs2 = 1'b1;
                rd_write = 1'b1;
            end
            opc_op_imm: rd_write = 1'b1;
            opc_lui: begin
                op_class = class_lui;
                imm      = {instr[31:12], 12'b0};
                uses_rs1 = 1'b0;
                rd_write = 1'b1;
            end
            opc_load: begin
                op_class = class_load;
                rd_write = 1'b1;
            end
            opc_store: begin
                op_class = class_store;
                imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                uses_rs2 = 1'b1;
            end
            opc_branch: begin
                op_class = class_branch;
                imm      = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
                uses_rs2 = 1'b1;
            end
            opc_jal: begin
                op_class = class_jal;
                imm      = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
                uses_rs1 = 1'b0;
                rd_write = 1'b1;
            end
            default: uses_rs1 = 1'b0;   // Unknown opcode runs as a nop
        endcase
    end

    // Exec result wins over writeback, x0 never bypassed
    function automatic word_t operand(reg_sel_t sel, word_t rf_data);
        if (sel == '0)
            return '0;
        if (bypass_exec_valid && bypass_exec.write && bypass_exec.rd == sel)
            return bypass_exec.result;
        if (bypass_wb_valid && bypass_wb.write && bypass_wb.rd == sel)
            return bypass_wb.result;
        return rf_data;
    endfunction

    // Source still being produced by our own output or a pending load
    function automatic logic blocked(reg_sel_t sel);
        return sel != '0 &&
               ((out_valid && decode_out.rd_write && decode_out.rd == sel) ||
                (load_pending && load_pending_rd == sel));
    endfunction

    assign rs1_val = operand(rs1, read1_data);
    assign rs2_val = operand(rs2, read2_data);
    assign hazard  = (uses_rs1 && blocked(rs1)) || (uses_rs2 && blocked(rs2));

    assign stall_prev = hazard || (out_valid && next_stalled) || flush;
    assign accept     = !prev_stalled && !stall_prev;
    assign stall_next = !out_valid;

    always_ff @(posedge clk) begin
        if (accept) begin
            decode_out.op_class   <= op_class;
            decode_out.alu_fn     <= {opcode == opc_op && instr[30], funct3};
            decode_out.rd         <= rd;
            decode_out.rd_write   <= rd_write && rd != '0;
            decode_out.op_a       <= rs1_val;
            decode_out.op_b       <= uses_rs2 && opcode != opc_store ? rs2_val : imm;
            decode_out.store_data <= rs2_val;
            decode_out.imm        <= imm;
            decode_out.addr       <= fetch_in.addr;
            decode_out.bne        <= funct3[0];
        end

        if (rst || flush)
            out_valid <= 1'b0;
        else if (accept)
            out_valid <= 1'b1;
        else if (!next_stalled)
            out_valid <= 1'b0;
    end

endmodule

//--- src/exec.sv
`timescale 1ns/1ps

module exec import core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  decode_out_t decode_in,
    input  logic        prev_stalled,
    output logic        stall_prev,
    output logic        stall_next,
    output exec_out_t   exec_out,
    output logic        flush,
    output addr_t       redirect_addr,
    output dmem_req_t   dmem_req,
    input  mem_rsp_t    dmem_rsp,
    output reg_sel_t    load_pending_rd,
    output logic        load_pending
);

    typedef enum logic {
        exec_idle,
        exec_wait
    } exec_state_t;

    exec_state_t state;
    logic  out_valid;
    logic  taken;           // Registered with the output, drives flush
    logic  accept;
    logic  is_mem;
    logic  take_branch;
    addr_t target, link_addr;
    word_t result;

    function automatic word_t alu(logic [3:0] fn, word_t a, word_t b);
        case (fn[2:0])
            3'b000:  return fn[3] ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    assign stall_prev = state != exec_idle || flush;
    assign accept     = !prev_stalled && !stall_prev;
    assign stall_next = !out_valid;
    assign flush      = out_valid && taken;

    assign is_mem    = decode_in.op_class == class_load || decode_in.op_class == class_store;
    assign target    = decode_in.addr + decode_in.imm;
    assign link_addr = decode_in.addr + 32'd4;

    always_comb begin
        take_branch = 1'b0;
        case (decode_in.op_class)
            class_branch: take_branch = (decode_in.op_a == decode_in.op_b) ^ decode_in.bne;
            class_jal:    take_branch = 1'b1;
            default:      take_branch = 1'b0;
        endcase
    end

    always_comb begin
        case (decode_in.op_class)
            class_alu: result = alu(decode_in.alu_fn, decode_in.op_a, decode_in.op_b);
            class_lui: result = decode_in.imm;
            class_jal: result = link_addr;
            default:   result = '0;     // Loads fill in on ack
        endcase
    end

    // Only a load in flight has a destination here
    assign load_pending    = state == exec_wait && exec_out.write;
    assign load_pending_rd = exec_out.rd;

    always_ff @(posedge clk) begin
        if (accept) begin
            exec_out.rd      <= decode_in.rd;
            exec_out.write   <= decode_in.rd_write;
            exec_out.result  <= result;
            exec_out.addr    <= decode_in.addr;
            exec_out.next_pc <= take_branch ? target : link_addr;
            redirect_addr    <= target;
            dmem_req.write   <= decode_in.op_class == class_store;
            dmem_req.addr    <= decode_in.op_a + decode_in.imm;
            dmem_req.wdata   <= decode_in.store_data;
        end
        if (state == exec_wait && dmem_rsp.ack)
            exec_out.result <= dmem_rsp.rdata;

        if (rst) begin
            state        <= exec_idle;
            out_valid    <= 1'b0;
            taken        <= 1'b0;
            dmem_req.req <= 1'b0;
        end else begin
            out_valid <= 1'b0;      // Writeback takes every valid output
            taken     <= 1'b0;
            case (state)
                exec_idle: begin
                    if (accept && is_mem) begin
                        state        <= exec_wait;
                        dmem_req.req <= 1'b1;
                    end else if (accept) begin
                        out_valid <= 1'b1;
                        taken     <= take_branch;
                    end
                end
                default: begin
                    if (dmem_rsp.ack) begin
                        state        <= exec_idle;
                        dmem_req.req <= 1'b0;
                        out_valid    <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- src/writeback.sv
`timescale 1ns/1ps

module writeback import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  exec_out_t exec_in,
    input  logic      prev_stalled,
    output exec_out_t wb_out,
    output logic      wb_valid,
    output logic      reg_write_enable,
    output addr_t     reg_pc
);

    assign reg_write_enable = wb_valid && wb_out.write;

    always_ff @(posedge clk) begin
        if (!prev_stalled)
            wb_out <= exec_in;

        if (rst) begin
            wb_valid <= 1'b0;
            reg_pc   <= reset_pc;
        end else begin
            wb_valid <= !prev_stalled;
            if (!prev_stalled)
                reg_pc <= exec_in.next_pc;  // Commit moves with the valid flag
        end
    end

endmodule

//--- src/core.sv
`timescale 1ns/1ps

module core import core_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    output imem_req_t  imem_req,
    input  mem_rsp_t   imem_rsp,
    output dmem_req_t  dmem_req,
    input  mem_rsp_t   dmem_rsp,
    input  reg_sel_t   reg_read_sel,
    output word_t      reg_read_data,
    output addr_t      reg_pc,
    output fetch_out_t fetch_instr
);

    reg_sel_t clear_sel;
    logic     clearing;

    // Walk x31 down to x1 once reset drops
    always_ff @(posedge clk) begin
        if (rst) begin
            clear_sel <= 5'd31;
            clearing  <= 1'b1;
        end else if (clearing) begin
            clear_sel <= clear_sel - 5'd1;
            if (clear_sel == 5'd1)
                clearing <= 1'b0;
        end
    end

    logic        ifetch_stall_next, ifetch_next_stalled;
    logic        decode_stall_next, decode_next_stalled;
    logic        exec_stall_next;
    logic        exec_flush;
    addr_t       exec_redirect;
    reg_sel_t    read1_sel, read2_sel;
    word_t       read1_data, read2_data;
    decode_out_t decode_out;
    exec_out_t   exec_out;
    exec_out_t   wb_out;
    logic        wb_valid, wb_write_enable;
    reg_sel_t    load_pending_rd;
    logic        load_pending;

    ifetch ifetch_i (
        .clk,
        .rst,
        .flush         (exec_flush || clearing),    // Fetch held off while clearing
        .redirect_addr (clearing ? reset_pc : exec_redirect),
        .imem_req,
        .imem_rsp,
        .fetch_out     (fetch_instr),
        .next_stalled  (ifetch_next_stalled),
        .stall_next    (ifetch_stall_next)
    );

    decode decode_i (
        .clk,
        .rst,
        .flush             (exec_flush),
        .fetch_in          (fetch_instr),
        .prev_stalled      (ifetch_stall_next),
        .stall_prev        (ifetch_next_stalled),
        .next_stalled      (decode_next_stalled),
        .stall_next        (decode_stall_next),
        .read1_sel,
        .read2_sel,
        .read1_data,
        .read2_data,
        .bypass_exec       (exec_out),
        .bypass_exec_valid (!exec_stall_next),
        .bypass_wb         (wb_out),
        .bypass_wb_valid   (wb_valid),
        .load_pending_rd,
        .load_pending,
        .decode_out
    );

    exec exec_i (
        .clk,
        .rst,
        .decode_in     (decode_out),
        .prev_stalled  (decode_stall_next),
        .stall_prev    (decode_next_stalled),
        .stall_next    (exec_stall_next),
        .exec_out,
        .flush         (exec_flush),
        .redirect_addr (exec_redirect),
        .dmem_req,
        .dmem_rsp,
        .load_pending_rd,
        .load_pending
    );

    writeback writeback_i (
        .clk,
        .rst,
        .exec_in          (exec_out),
        .prev_stalled     (exec_stall_next),
        .wb_out,
        .wb_valid,
        .reg_write_enable (wb_write_enable),
        .reg_pc
    );

    int_regfile regs_i (
        .clk,
        .rst,
        .write_enable (clearing || wb_write_enable),
        .write_sel    (clearing ? clear_sel : wb_out.rd),
        .write_data   (clearing ? '0 : wb_out.result),
        .read1_sel,
        .read2_sel,
        .read3_sel    (reg_read_sel),
        .read1_data,
        .read2_data,
        .read3_data   (reg_read_data)
    );

endmodule

//--- tb/core_tb.sv
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

    localparam int          timeout_cycles = 5 * 2000;
    localparam logic [31:0] seed           = 32'hc459_492d;
    localparam instr_t      nop            = 32'h0000_0013;    // addi x0, x0, 0

    logic       clk;
    logic       rst;
    imem_req_t  imem_req;
    mem_rsp_t   imem_rsp;
    dmem_req_t  dmem_req;
    mem_rsp_t   dmem_rsp;
    reg_sel_t   reg_read_sel;
    word_t      reg_read_data;
    addr_t      reg_pc;
    fetch_out_t fetch_instr;

    instr_t      imem [256];
    word_t       dmem [256];
    instr_t      prog [$];      // Program staged for the next run
    logic [31:0] op_rng    = seed;
    logic [31:0] delay_rng = seed;
    int          errors    = 0;
    int          checks    = 0;
    int          cycles    = 0;

    // Memory model state, one request in flight per port
    logic       i_busy, d_busy, d_write;
    logic [1:0] i_count, d_count;
    addr_t      i_addr, d_addr;
    word_t      d_wdata;

    core core_i (
        .clk,
        .rst,
        .imem_req,
        .imem_rsp,
        .dmem_req,
        .dmem_rsp,
        .reg_read_sel,
        .reg_read_data,
        .reg_pc,
        .fetch_instr
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t next_rand();
        op_rng = xorshift(op_rng);
        return op_rng;
    endfunction

    function automatic word_t fill_value(addr_t a);
        return a ^ 32'h5ee0_0000;
    endfunction

    // Ack lands 1 to 4 cycles after the model picks up a request
    always @(posedge clk) begin
        imem_rsp.ack <= 1'b0;
        dmem_rsp.ack <= 1'b0;
        if (rst) begin
            i_busy <= 1'b0;
            d_busy <= 1'b0;
        end else begin
            if (i_busy) begin
                if (i_count == 2'd0) begin
                    imem_rsp.ack   <= 1'b1;
                    imem_rsp.rdata <= imem[i_addr[9:2]];
                    i_busy         <= 1'b0;
                end else begin
                    i_count <= i_count - 2'd1;
                end
            end else if (imem_req.req && !imem_rsp.ack) begin
                delay_rng = xorshift(delay_rng);
                i_busy    <= 1'b1;
                i_addr    <= imem_req.addr;
                i_count   <= delay_rng[1:0];
            end

            if (d_busy) begin
                if (d_count == 2'd0) begin
                    dmem_rsp.ack <= 1'b1;
                    if (d_write)
                        dmem[d_addr[9:2]] <= d_wdata;
                    else
                        dmem_rsp.rdata <= dmem[d_addr[9:2]];
                    d_busy <= 1'b0;
                end else begin
                    d_count <= d_count - 2'd1;
                end
            end else if (dmem_req.req && !dmem_rsp.ack) begin
                delay_rng = xorshift(delay_rng);
                d_busy    <= 1'b1;
                d_write   <= dmem_req.write;
                d_addr    <= dmem_req.addr;
                d_wdata   <= dmem_req.wdata;
                d_count   <= delay_rng[1:0];
            end
        end
    end

    function automatic instr_t r_type(logic [6:0] f7, reg_sel_t rs2, reg_sel_t rs1,
                                      logic [2:0] f3, reg_sel_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic instr_t i_type(logic [6:0] opc, logic [2:0] f3, reg_sel_t rd,
                                      reg_sel_t rs1, int imm);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic instr_t s_type(reg_sel_t rs2, reg_sel_t rs1, int imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic instr_t b_type(logic [2:0] f3, reg_sel_t rs1, reg_sel_t rs2, int off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
    endfunction

    function automatic instr_t u_type(reg_sel_t rd, logic [19:0] upper);
        return {upper, rd, opc_lui};
    endfunction

    function automatic instr_t j_type(reg_sel_t rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
    endfunction

    function automatic instr_t addi(reg_sel_t rd, reg_sel_t rs1, int imm);
        return i_type(opc_op_imm, 3'b000, rd, rs1, imm);
    endfunction

    // LUI plus ADDI, upper part rounded for the sign of the low 12 bits
    task automatic load_const(reg_sel_t rd, word_t value);
        word_t rounded;
        rounded = value + 32'h800;
        prog.push_back(u_type(rd, rounded[31:12]));
        prog.push_back(addi(rd, rd, int'(value[11:0])));
    endtask

    task automatic compare_word(string what, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_addr(string what, addr_t got, addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_fetch(string what, fetch_out_t got, fetch_out_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %h/%h, expected %h/%h", $time, what,
                     got.addr, got.instr, exp.addr, exp.instr);
        end
    endtask

    // Reset with the staged program in memory and a fresh data pattern
    task automatic start_program();
        int i;
        @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        for (i = 0; i < 256; i++) begin
            imem[i] = i < prog.size() ? prog[i] : nop;
            dmem[i] = fill_value(addr_t'(i) << 2);
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic wait_for_pc(addr_t loop_addr);
        do
            @(negedge clk);
        while (reg_pc !== loop_addr);
    endtask

    task automatic run_program(addr_t loop_addr);
        start_program();
        wait_for_pc(loop_addr);
    endtask

    task automatic check_reg(reg_sel_t sel, word_t exp);
        @(posedge clk);
        reg_read_sel <= sel;
        @(negedge clk);
        compare_word($sformatf("x%0d", sel), reg_read_data, exp);
    endtask

    task automatic reset_clearing();
        int r;
        prog.delete();
        for (r = 1; r < 32; r++)
            prog.push_back(addi(reg_sel_t'(r), 0, r * 9 + 2));
        prog.push_back(j_type(0, 0));
        run_program(addr_t'(31 * 4));
        for (r = 1; r < 32; r++)
            check_reg(reg_sel_t'(r), word_t'(r * 9 + 2));

        prog.delete();
        prog.push_back(nop);
        prog.push_back(j_type(0, 0));
        start_program();
        do
            @(negedge clk);
        while (!imem_req.req);
        compare_addr("first fetch request", imem_req.addr, reset_pc);
        while (!imem_rsp.ack)
            @(negedge clk);
        @(negedge clk);
        compare_fetch("first fetched instruction", fetch_instr, '{addr: reset_pc, instr: nop});
        wait_for_pc(addr_t'(4));
        for (r = 1; r < 32; r++)
            check_reg(reg_sel_t'(r), '0);
    endtask

    task automatic alu_and_lui();
        word_t      a, b, r, imm;
        word_t      exp_val [1:18];
        logic [4:0] sh;
        int         p, k;
        for (p = 0; p < 20; p++) begin
            a   = next_rand();
            b   = next_rand();
            r   = next_rand();
            imm = {{20{r[11]}}, r[11:0]};
            sh  = r[4:0];
            prog.delete();
            load_const(1, a);
            load_const(2, b);
            prog.push_back(r_type(7'h00, 2, 1, 3'b000, 3));
            prog.push_back(r_type(7'h20, 2, 1, 3'b000, 4));   // sub
            prog.push_back(r_type(7'h00, 2, 1, 3'b111, 5));
            prog.push_back(r_type(7'h00, 2, 1, 3'b110, 6));
            prog.push_back(r_type(7'h00, 2, 1, 3'b100, 7));
            prog.push_back(r_type(7'h00, 2, 1, 3'b010, 8));
            prog.push_back(r_type(7'h00, 2, 1, 3'b001, 9));
            prog.push_back(r_type(7'h00, 2, 1, 3'b101, 10));
            prog.push_back(i_type(opc_op_imm, 3'b000, 11, 1, int'(r[11:0])));
            prog.push_back(i_type(opc_op_imm, 3'b111, 12, 1, int'(r[11:0])));
            prog.push_back(i_type(opc_op_imm, 3'b110, 13, 1, int'(r[11:0])));
            prog.push_back(i_type(opc_op_imm, 3'b100, 14, 1, int'(r[11:0])));
            prog.push_back(i_type(opc_op_imm, 3'b010, 15, 1, int'(r[11:0])));
            prog.push_back(i_type(opc_op_imm, 3'b001, 16, 1, int'(sh)));
            prog.push_back(i_type(opc_op_imm, 3'b101, 17, 1, int'(sh)));
            prog.push_back(u_type(18, a[31:12]));
            prog.push_back(j_type(0, 0));

            exp_val[1]  = a;
            exp_val[2]  = b;
            exp_val[3]  = a + b;
            exp_val[4]  = a - b;
            exp_val[5]  = a & b;
            exp_val[6]  = a | b;
            exp_val[7]  = a ^ b;
            exp_val[8]  = $signed(a) < $signed(b) ? 32'd1 : 32'd0;
            exp_val[9]  = a << b[4:0];
            exp_val[10] = a >> b[4:0];
            exp_val[11] = a + imm;
            exp_val[12] = a & imm;
            exp_val[13] = a | imm;
            exp_val[14] = a ^ imm;
            exp_val[15] = $signed(a) < $signed(imm) ? 32'd1 : 32'd0;
            exp_val[16] = a << sh;
            exp_val[17] = a >> sh;
            exp_val[18] = {a[31:12], 12'b0};

            run_program(addr_t'((prog.size() - 1) * 4));
            for (k = 1; k <= 18; k++)
                check_reg(reg_sel_t'(k), exp_val[k]);
        end
    endtask

    // Each add needs the previous two results with no gap between them
    task automatic dependency_chain();
        word_t exp_val [1:25];
        int    k;
        exp_val[1] = next_rand();
        exp_val[2] = next_rand();
        prog.delete();
        load_const(1, exp_val[1]);
        load_const(2, exp_val[2]);
        for (k = 3; k <= 25; k++) begin
            prog.push_back(r_type(7'h00, reg_sel_t'(k - 2), reg_sel_t'(k - 1), 3'b000,
                                  reg_sel_t'(k)));
            exp_val[k] = exp_val[k - 1] + exp_val[k - 2];
        end
        prog.push_back(j_type(0, 0));
        run_program(addr_t'((prog.size() - 1) * 4));
        for (k = 1; k <= 25; k++)
            check_reg(reg_sel_t'(k), exp_val[k]);
    endtask

    task automatic load_store();
        word_t v;
        v = next_rand();
        prog.delete();
        prog.push_back(addi(1, 0, 32'h40));    // Base address
        load_const(2, v);
        prog.push_back(addi(3, 2, 1));
        prog.push_back(s_type(2, 1, 0));
        prog.push_back(s_type(3, 1, 8));
        prog.push_back(i_type(opc_load, 3'b010, 4, 1, 0));
        prog.push_back(r_type(7'h00, 4, 4, 3'b000, 5));
        prog.push_back(i_type(opc_load, 3'b010, 6, 1, 8));
        prog.push_back(addi(7, 6, -1));
        prog.push_back(i_type(opc_load, 3'b010, 8, 1, 16));  // Untouched word
        prog.push_back(r_type(7'h00, 6, 8, 3'b000, 9));
        prog.push_back(j_type(0, 0));
        run_program(addr_t'((prog.size() - 1) * 4));

        compare_word("dmem[0x40]", dmem[32'h40 >> 2], v);
        compare_word("dmem[0x44]", dmem[32'h44 >> 2], fill_value(32'h44));
        compare_word("dmem[0x48]", dmem[32'h48 >> 2], v + 32'd1);
        check_reg(4, v);
        check_reg(5, v + v);
        check_reg(6, v + 32'd1);
        check_reg(7, v);
        check_reg(8, fill_value(32'h50));
        check_reg(9, fill_value(32'h50) + v + 32'd1);
    endtask

    task automatic control_flow();
        prog.delete();
        prog.push_back(addi(1, 0, 7));
        prog.push_back(addi(2, 0, 7));
        prog.push_back(addi(3, 0, 9));
        prog.push_back(nop);
        prog.push_back(b_type(3'b000, 1, 2, 8));     // beq taken
        prog.push_back(addi(10, 0, 1));
        prog.push_back(b_type(3'b001, 1, 3, 8));     // bne taken
        prog.push_back(addi(11, 0, 1));
        prog.push_back(b_type(3'b000, 1, 3, 8));     // beq not taken
        prog.push_back(addi(12, 0, 1));
        prog.push_back(b_type(3'b001, 1, 2, 8));     // bne not taken
        prog.push_back(addi(13, 0, 1));
        prog.push_back(j_type(5, 12));
        prog.push_back(addi(14, 0, 1));
        prog.push_back(addi(14, 0, 2));
        prog.push_back(addi(15, 5, 0));
        prog.push_back(addi(6, 0, 3));
        prog.push_back(addi(6, 6, -1));              // Three passes back from the bne
        prog.push_back(addi(7, 7, 2));
        prog.push_back(b_type(3'b001, 6, 0, -8));
        prog.push_back(j_type(0, 0));
        run_program(addr_t'(20 * 4));

        check_reg(10, '0);
        check_reg(11, '0);
        check_reg(12, 32'd1);
        check_reg(13, 32'd1);
        check_reg(14, '0);
        check_reg(5, 32'd52);
        check_reg(15, 32'd52);
        check_reg(6, '0);
        check_reg(7, 32'd6);
        compare_addr("final reg_pc", reg_pc, addr_t'(20 * 4));
    endtask

    initial begin : watchdog
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        imem_rsp     = '0;
        dmem_rsp     = '0;
        reg_read_sel = '0;

        reset_clearing();
        alu_and_lui();
        dependency_chain();
        load_store();
        control_flow();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- vlog.f
src/core_pkg.sv
src/int_regfile.sv
src/ifetch.sv
src/decode.sv
src/exec.sv
src/writeback.sv
src/core.sv
tb/core_tb.sv

//--- Bender.yml
package:
  name: core

sources:
  - src/core_pkg.sv
  - src/int_regfile.sv
  - src/ifetch.sv
  - src/decode.sv
  - src/exec.sv
  - src/writeback.sv
  - src/core.sv
  - target: test
    files:
      - tb/core_tb.sv
